// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

  //////////////////////////////
  // Widths and default counts.
  //////////////////////////////

  localparam int word_w = 64;
  localparam int half_w = word_w / 2;

  localparam int num_ext_buses = 2;
  localparam int num_lanes = 2;

  typedef logic [word_w-1:0] word_t;

  // Carry sits in the top bit.
  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic overflow;
  } flags_t;

  //////////////////////////////
  // Issue-side encodings.
  //////////////////////////////

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_adc,
    op_and,
    op_or,
    op_xor,
    op_shl,
    op_shr,
    op_sar
  } alu_op_t;

  typedef enum logic [1:0] {
    src_reg,
    src_bus_now,
    src_bus_prev
  } src_t;

  // Decoded controls between decoder and ALU.
  typedef enum logic [1:0] {
    cin_zero,
    cin_one,
    cin_flag
  } carry_sel_t;

  typedef enum logic [1:0] {
    fn_and,
    fn_or,
    fn_xor
  } logic_fn_t;

  typedef enum logic [1:0] {
    unit_adder,
    unit_logic,
    unit_shift
  } unit_t;

endpackage

`default_nettype wire

// File: logic/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import exec_pkg::*; #(
  parameter type payload_t = word_t,
  parameter int num_buses = num_ext_buses + num_lanes,
  localparam int sel_w = (num_buses > 1) ? $clog2(num_buses) : 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             issue_valid,
  input  src_t             src,
  input  logic [sel_w-1:0] bus_sel,
  input  payload_t         operand,
  input  payload_t         bus_now [num_buses],
  input  payload_t         bus_prev [num_buses],
  output payload_t         value
);

  payload_t picked;

  // Bus valid is not checked here, the scheduler only issues ready sources.
  always_comb begin
    case (src)
      src_bus_now: begin
        picked = bus_now[bus_sel];
      end
      src_bus_prev: begin
        picked = bus_prev[bus_sel];
      end
      default: begin
        picked = operand;
      end
    endcase
  end

  // Captured at issue and held until the next issue.
  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (issue_valid) begin
      value <= picked;
    end
  end

endmodule

`default_nettype wire

// File: logic/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode import exec_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       issue_valid,
  input  alu_op_t    issue_op,
  input  logic       issue_narrow,
  output logic       invert_b,
  output carry_sel_t carry_sel,
  output logic_fn_t  logic_fn,
  output unit_t      unit_sel,
  output logic       shift_left,
  output logic       shift_arith,
  output logic       narrow
);

  logic       dec_invert_b;
  carry_sel_t dec_carry_sel;
  logic_fn_t  dec_logic_fn;
  unit_t      dec_unit_sel;

  always_comb begin
    dec_invert_b = 1'b0;
    dec_carry_sel = cin_zero;
    dec_logic_fn = fn_and;
    dec_unit_sel = unit_adder;
    case (issue_op)
      op_sub: begin
        // Two's complement subtract.
        dec_invert_b = 1'b1;
        dec_carry_sel = cin_one;
      end
      op_adc: begin
        dec_carry_sel = cin_flag;
      end
      op_and: begin
        dec_unit_sel = unit_logic;
        dec_logic_fn = fn_and;
      end
      op_or: begin
        dec_unit_sel = unit_logic;
        dec_logic_fn = fn_or;
      end
      op_xor: begin
        dec_unit_sel = unit_logic;
        dec_logic_fn = fn_xor;
      end
      op_shl, op_shr, op_sar: begin
        dec_unit_sel = unit_shift;
      end
      default: begin
        dec_unit_sel = unit_adder;
      end
    endcase
  end

  // Precomputed at issue so the execute cycle sees flops only.
  always_ff @(posedge clk) begin
    if (reset) begin
      invert_b <= 1'b0;
      carry_sel <= cin_zero;
      logic_fn <= fn_and;
      unit_sel <= unit_adder;
      shift_left <= 1'b0;
      shift_arith <= 1'b0;
      narrow <= 1'b0;
    end else if (issue_valid) begin
      invert_b <= dec_invert_b;
      carry_sel <= dec_carry_sel;
      logic_fn <= dec_logic_fn;
      unit_sel <= dec_unit_sel;
      shift_left <= (issue_op == op_shl);
      shift_arith <= (issue_op == op_sar);
      narrow <= issue_narrow;
    end
  end

endmodule

`default_nettype wire

// File: logic/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu import exec_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       in_valid,
  input  word_t      a,
  input  word_t      b,
  input  flags_t     flags_in,
  input  logic       invert_b,
  input  carry_sel_t carry_sel,
  input  logic_fn_t  logic_fn,
  input  unit_t      unit_sel,
  input  logic       shift_left,
  input  logic       shift_arith,
  input  logic       narrow,
  output word_t      result_data,
  output flags_t     result_flags,
  output logic       result_valid
);

  word_t             b_eff;
  logic              cin;
  logic [word_w:0]   sum_wide;
  logic [half_w:0]   sum_low;
  logic              ovf_wide;
  logic              ovf_low;
  word_t             logic_res;
  word_t             shift_src;
  logic              shift_fill;
  logic [5:0]        shamt;
  logic [word_w:0]   lsh;
  logic [word_w+1:0] rsh_in;
  logic [word_w+1:0] rsh;
  logic              shift_carry;
  word_t             raw;
  word_t             res;
  flags_t            flags;

  //////////////////////////////
  // Adder.
  //////////////////////////////

  assign b_eff = invert_b ? ~b : b;

  always_comb begin
    case (carry_sel)
      cin_one:  cin = 1'b1;
      cin_flag: cin = flags_in.carry;
      default:  cin = 1'b0;
    endcase
  end

  assign sum_wide = {1'b0, a} + {1'b0, b_eff} + (word_w + 1)'(cin);
  assign sum_low = {1'b0, a[half_w-1:0]} + {1'b0, b_eff[half_w-1:0]} + (half_w + 1)'(cin);

  // Operands agree in sign but the sum does not.
  assign ovf_wide = (a[word_w-1] == b_eff[word_w-1]) && (sum_wide[word_w-1] != a[word_w-1]);
  assign ovf_low = (a[half_w-1] == b_eff[half_w-1]) && (sum_low[half_w-1] != a[half_w-1]);

  //////////////////////////////
  // Logic unit and shifter.
  //////////////////////////////

  always_comb begin
    case (logic_fn)
      fn_or:   logic_res = a | b;
      fn_xor:  logic_res = a ^ b;
      default: logic_res = a & b;
    endcase
  end

  // Narrow source is extended so one 64-bit shifter serves both sizes.
  assign shift_src = narrow ? {{half_w{shift_arith & a[half_w-1]}}, a[half_w-1:0]} : a;
  assign shift_fill = shift_arith & shift_src[word_w-1];
  assign shamt = narrow ? {1'b0, b[4:0]} : b[5:0];

  // Extra bit below the word catches the last bit out on right shifts.
  assign lsh = {1'b0, shift_src} << shamt;
  assign rsh_in = {shift_fill, shift_src, 1'b0};
  assign rsh = $signed(rsh_in) >>> shamt;

  always_comb begin
    if (shift_left) begin
      shift_carry = narrow ? lsh[half_w] : lsh[word_w];
    end else begin
      shift_carry = rsh[0];
    end
  end

  //////////////////////////////
  // Result and flags.
  //////////////////////////////

  always_comb begin
    case (unit_sel)
      unit_logic: raw = logic_res;
      unit_shift: raw = shift_left ? lsh[word_w-1:0] : rsh[word_w:1];
      default:    raw = sum_wide[word_w-1:0];
    endcase
    res = narrow ? {{half_w{1'b0}}, raw[half_w-1:0]} : raw;

    case (unit_sel)
      unit_adder: flags.carry = narrow ? sum_low[half_w] : sum_wide[word_w];
      unit_shift: flags.carry = shift_carry;
      default:    flags.carry = 1'b0;
    endcase
    flags.zero = (res == '0);
    flags.sign = narrow ? res[half_w-1] : res[word_w-1];
    flags.overflow = (unit_sel == unit_adder) && (narrow ? ovf_low : ovf_wide);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      result_data <= res;
      result_flags <= flags;
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exec_lane import exec_pkg::*; #(
  parameter int num_lanes = exec_pkg::num_lanes,
  parameter int num_ext_buses = exec_pkg::num_ext_buses,
  localparam int num_buses = num_ext_buses + num_lanes,
  localparam int sel_w = (num_buses > 1) ? $clog2(num_buses) : 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             issue_valid,
  input  alu_op_t          issue_op,
  input  logic             issue_narrow,
  input  word_t            issue_a,
  input  word_t            issue_b,
  input  flags_t           issue_flags,
  input  src_t             a_src,
  input  logic [sel_w-1:0] a_bus_sel,
  input  src_t             b_src,
  input  logic [sel_w-1:0] b_bus_sel,
  input  src_t             flags_src,
  input  logic [sel_w-1:0] flags_bus_sel,
  input  word_t            bus_data [num_buses],
  input  flags_t           bus_flags [num_buses],
  input  word_t            bus_prev_data [num_buses],
  input  flags_t           bus_prev_flags [num_buses],
  output word_t            result_data,
  output flags_t           result_flags,
  output logic             result_valid
);

  logic       valid_q;
  word_t      a_q;
  word_t      b_q;
  flags_t     flags_q;
  logic       invert_b;
  carry_sel_t carry_sel;
  logic_fn_t  logic_fn;
  unit_t      unit_sel;
  logic       shift_left;
  logic       shift_arith;
  logic       narrow;

  // Valid travels with the operand registers.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid;
    end
  end

  operand_bypass #(.payload_t(word_t), .num_buses(num_buses)) u_a_bypass (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .src         (a_src),
    .bus_sel     (a_bus_sel),
    .operand     (issue_a),
    .bus_now     (bus_data),
    .bus_prev    (bus_prev_data),
    .value       (a_q)
  );

  operand_bypass #(.payload_t(word_t), .num_buses(num_buses)) u_b_bypass (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .src         (b_src),
    .bus_sel     (b_bus_sel),
    .operand     (issue_b),
    .bus_now     (bus_data),
    .bus_prev    (bus_prev_data),
    .value       (b_q)
  );

  operand_bypass #(.payload_t(flags_t), .num_buses(num_buses)) u_flags_bypass (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .src         (flags_src),
    .bus_sel     (flags_bus_sel),
    .operand     (issue_flags),
    .bus_now     (bus_flags),
    .bus_prev    (bus_prev_flags),
    .value       (flags_q)
  );

  op_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_narrow (issue_narrow),
    .invert_b     (invert_b),
    .carry_sel    (carry_sel),
    .logic_fn     (logic_fn),
    .unit_sel     (unit_sel),
    .shift_left   (shift_left),
    .shift_arith  (shift_arith),
    .narrow       (narrow)
  );

  int_alu u_alu (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (valid_q),
    .a            (a_q),
    .b            (b_q),
    .flags_in     (flags_q),
    .invert_b     (invert_b),
    .carry_sel    (carry_sel),
    .logic_fn     (logic_fn),
    .unit_sel     (unit_sel),
    .shift_left   (shift_left),
    .shift_arith  (shift_arith),
    .narrow       (narrow),
    .result_data  (result_data),
    .result_flags (result_flags),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// File: logic/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster import exec_pkg::*; #(
  parameter int num_lanes = exec_pkg::num_lanes,
  parameter int num_ext_buses = exec_pkg::num_ext_buses,
  localparam int num_buses = num_ext_buses + num_lanes,
  localparam int sel_w = (num_buses > 1) ? $clog2(num_buses) : 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             issue_valid [num_lanes],
  input  alu_op_t          issue_op [num_lanes],
  input  logic             issue_narrow [num_lanes],
  input  word_t            issue_a [num_lanes],
  input  word_t            issue_b [num_lanes],
  input  flags_t           issue_flags [num_lanes],
  input  src_t             a_src [num_lanes],
  input  logic [sel_w-1:0] a_bus_sel [num_lanes],
  input  src_t             b_src [num_lanes],
  input  logic [sel_w-1:0] b_bus_sel [num_lanes],
  input  src_t             flags_src [num_lanes],
  input  logic [sel_w-1:0] flags_bus_sel [num_lanes],
  input  word_t            ext_bus_data [num_ext_buses],
  input  flags_t           ext_bus_flags [num_ext_buses],
  input  logic             ext_bus_valid [num_ext_buses],
  output word_t            result_data [num_lanes],
  output flags_t           result_flags [num_lanes],
  output logic             result_valid [num_lanes]
);

  word_t  bus_data [num_buses];
  flags_t bus_flags [num_buses];
  word_t  bus_prev_data [num_buses];
  flags_t bus_prev_flags [num_buses];

  //////////////////////////////
  // Result buses.
  //////////////////////////////

  // External slots first, then one slot per lane.
  always_comb begin
    for (int i = 0; i < num_ext_buses; i++) begin
      bus_data[i] = ext_bus_data[i];
      bus_flags[i] = ext_bus_flags[i];
    end
    for (int j = 0; j < num_lanes; j++) begin
      bus_data[num_ext_buses+j] = result_data[j];
      bus_flags[num_ext_buses+j] = result_flags[j];
    end
  end

  // One-cycle history of every bus.
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_buses; i++) begin
      if (reset) begin
        bus_prev_data[i] <= '0;
        bus_prev_flags[i] <= '0;
      end else begin
        bus_prev_data[i] <= bus_data[i];
        bus_prev_flags[i] <= bus_flags[i];
      end
    end
  end

  //////////////////////////////
  // Lanes.
  //////////////////////////////

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    exec_lane #(.num_lanes(num_lanes), .num_ext_buses(num_ext_buses)) u_lane (
      .clk            (clk),
      .reset          (reset),
      .issue_valid    (issue_valid[l]),
      .issue_op       (issue_op[l]),
      .issue_narrow   (issue_narrow[l]),
      .issue_a        (issue_a[l]),
      .issue_b        (issue_b[l]),
      .issue_flags    (issue_flags[l]),
      .a_src          (a_src[l]),
      .a_bus_sel      (a_bus_sel[l]),
      .b_src          (b_src[l]),
      .b_bus_sel      (b_bus_sel[l]),
      .flags_src      (flags_src[l]),
      .flags_bus_sel  (flags_bus_sel[l]),
      .bus_data       (bus_data),
      .bus_flags      (bus_flags),
      .bus_prev_data  (bus_prev_data),
      .bus_prev_flags (bus_prev_flags),
      .result_data    (result_data[l]),
      .result_flags   (result_flags[l]),
      .result_valid   (result_valid[l])
    );
  end

endmodule

`default_nettype wire

// File: sim/exec_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exec_assert import exec_pkg::*; (
  input wire logic  clk,
  input wire logic  reset,
  input wire logic  issue_valid,
  input wire logic  issue_narrow,
  input wire logic  result_valid,
  input wire word_t result_data
);

  int error_count = 0;

  // No result may be reported in the cycle after reset.
  reset_clears_valid: assert property (@(posedge clk) reset |=> !result_valid)
    else begin
      error_count++;
      $error("result_valid high after reset");
    end

  // Two edges from issue to result.
  valid_latency: assert property (@(posedge clk) disable iff (reset)
    result_valid == $past(issue_valid, 2))
    else begin
      error_count++;
      $error("result_valid does not follow issue_valid by two edges");
    end

  narrow_upper_zero: assert property (@(posedge clk) disable iff (reset)
    (result_valid && $past(issue_narrow, 2)) |-> (result_data[word_w-1:half_w] == '0))
    else begin
      error_count++;
      $error("narrow result has nonzero upper half");
    end

endmodule

`default_nettype wire

// File: sim/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker import exec_pkg::*; #(
  parameter int num_lanes = exec_pkg::num_lanes,
  parameter int num_ext_buses = exec_pkg::num_ext_buses,
  localparam int num_buses = num_ext_buses + num_lanes,
  localparam int sel_w = (num_buses > 1) ? $clog2(num_buses) : 1
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             issue_valid [num_lanes],
  input  wire alu_op_t          issue_op [num_lanes],
  input  wire logic             issue_narrow [num_lanes],
  input  wire word_t            issue_a [num_lanes],
  input  wire word_t            issue_b [num_lanes],
  input  wire flags_t           issue_flags [num_lanes],
  input  wire src_t             a_src [num_lanes],
  input  wire logic [sel_w-1:0] a_bus_sel [num_lanes],
  input  wire src_t             b_src [num_lanes],
  input  wire logic [sel_w-1:0] b_bus_sel [num_lanes],
  input  wire src_t             flags_src [num_lanes],
  input  wire logic [sel_w-1:0] flags_bus_sel [num_lanes],
  input  wire word_t            ext_bus_data [num_ext_buses],
  input  wire flags_t           ext_bus_flags [num_ext_buses],
  input  wire word_t            result_data [num_lanes],
  input  wire flags_t           result_flags [num_lanes],
  input  wire logic             result_valid [num_lanes],
  output int                    pass_count,
  output int                    fail_count,
  output int                    pending
);

  typedef struct packed {
    int     id;
    int     cyc;
    word_t  data;
    flags_t flags;
  } expect_t;

  expect_t exp_q [num_lanes][$];
  word_t   now_data [num_buses];
  flags_t  now_flags [num_buses];
  word_t   prev_data [num_buses];
  flags_t  prev_flags [num_buses];
  int      cycle;
  int      issued;

  //////////////////////////////
  // Reference ALU.
  //////////////////////////////

  task automatic model_alu(input alu_op_t op, input logic narrow, input word_t a,
                           input word_t b, input flags_t fin,
                           output word_t r, output flags_t f);
    int                     w;
    int                     amt;
    word_t                  mask;
    word_t                  sx;
    logic                   cin;
    logic [word_w:0]        full;
    logic signed [word_w+1:0] sa;
    logic signed [word_w+1:0] sb;
    logic signed [word_w+1:0] ssum;
    logic signed [word_w+1:0] smax;
    logic signed [word_w+1:0] smin;
    w = narrow ? half_w : word_w;
    mask = narrow ? {{half_w{1'b0}}, {half_w{1'b1}}} : '1;
    amt = narrow ? int'(b[4:0]) : int'(b[5:0]);
    sa = narrow ? $signed({{(half_w+2){a[half_w-1]}}, a[half_w-1:0]})
                : $signed({{2{a[word_w-1]}}, a});
    sb = narrow ? $signed({{(half_w+2){b[half_w-1]}}, b[half_w-1:0]})
                : $signed({{2{b[word_w-1]}}, b});
    sx = narrow ? {{half_w{a[half_w-1]}}, a[half_w-1:0]} : a;
    smax = (66'sd1 <<< (w - 1)) - 66'sd1;
    smin = -(66'sd1 <<< (w - 1));
    cin = (op == op_adc) ? fin.carry : 1'b0;
    f = '0;
    r = '0;
    case (op)
      op_add, op_adc: begin
        full = {1'b0, a & mask} + {1'b0, b & mask} + (word_w + 1)'(cin);
        ssum = sa + sb + 66'(cin);
        r = full[word_w-1:0] & mask;
        f.carry = full[w];
        f.overflow = (ssum > smax) || (ssum < smin);
      end
      op_sub: begin
        full = {1'b0, a & mask} + {1'b0, ~b & mask} + 65'd1;
        ssum = sa - sb;
        r = full[word_w-1:0] & mask;
        f.carry = full[w];
        f.overflow = (ssum > smax) || (ssum < smin);
      end
      op_and: r = a & b & mask;
      op_or:  r = (a | b) & mask;
      op_xor: r = (a ^ b) & mask;
      op_shl: begin
        r = (a << amt) & mask;
        f.carry = (amt == 0) ? 1'b0 : a[w-amt];
      end
      op_shr: begin
        r = (a & mask) >> amt;
        f.carry = (amt == 0) ? 1'b0 : a[amt-1];
      end
      default: begin
        r = word_t'($signed(sx) >>> amt) & mask;
        f.carry = (amt == 0) ? 1'b0 : sx[amt-1];
      end
    endcase
    f.zero = (r == '0);
    f.sign = r[w-1];
  endtask

  task automatic compare(input int lane, input expect_t e);
    logic ok;
    ok = 1'b1;
    if (e.cyc != cycle) begin
      $display("test %0d lane %0d arrived at cycle %0d instead of cycle %0d",
               e.id, lane, cycle, e.cyc);
      ok = 1'b0;
    end
    if (result_data[lane] !== e.data) begin
      $display("error at %0t: result_data[%0d] got %h expected %h",
               $time, lane, result_data[lane], e.data);
      ok = 1'b0;
    end
    if (result_flags[lane] !== e.flags) begin
      $display("error at %0t: result_flags[%0d] got %b expected %b",
               $time, lane, result_flags[lane], e.flags);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
      $display("test %0d lane %0d passed", e.id, lane);
    end else begin
      fail_count++;
      $display("test %0d lane %0d failed", e.id, lane);
    end
  endtask

  //////////////////////////////
  // Bus history and queues.
  //////////////////////////////

  always @(posedge clk) begin
    expect_t e;
    word_t   a;
    word_t   b;
    flags_t  fin;
    if (reset) begin
      for (int l = 0; l < num_lanes; l++) begin
        exp_q[l].delete();
      end
      for (int i = 0; i < num_buses; i++) begin
        now_data[i] = '0;
        now_flags[i] = '0;
        prev_data[i] = '0;
        prev_flags[i] = '0;
      end
      cycle = 0;
      pending = 0;
    end else begin
      cycle++;
      for (int l = 0; l < num_lanes; l++) begin
        if (result_valid[l]) begin
          if (exp_q[l].size() == 0) begin
            $display("lane %0d raised result_valid at %0t with no operation in flight",
                     l, $time);
            fail_count++;
          end else begin
            e = exp_q[l].pop_front();
            pending--;
            compare(l, e);
            // The lane's bus slot now carries this result.
            now_data[num_ext_buses+l] = e.data;
            now_flags[num_ext_buses+l] = e.flags;
          end
        end
      end
      for (int i = 0; i < num_ext_buses; i++) begin
        now_data[i] = ext_bus_data[i];
        now_flags[i] = ext_bus_flags[i];
      end
      for (int l = 0; l < num_lanes; l++) begin
        if (issue_valid[l]) begin
          a = (a_src[l] == src_bus_now) ? now_data[a_bus_sel[l]] :
              (a_src[l] == src_bus_prev) ? prev_data[a_bus_sel[l]] : issue_a[l];
          b = (b_src[l] == src_bus_now) ? now_data[b_bus_sel[l]] :
              (b_src[l] == src_bus_prev) ? prev_data[b_bus_sel[l]] : issue_b[l];
          fin = (flags_src[l] == src_bus_now) ? now_flags[flags_bus_sel[l]] :
                (flags_src[l] == src_bus_prev) ? prev_flags[flags_bus_sel[l]] :
                issue_flags[l];
          model_alu(issue_op[l], issue_narrow[l], a, b, fin, e.data, e.flags);
          e.id = issued;
          e.cyc = cycle + 2;
          issued++;
          exp_q[l].push_back(e);
          pending++;
        end
      end
      prev_data = now_data;
      prev_flags = now_flags;
    end
  end

  initial begin
    pass_count = 0;
    fail_count = 0;
    pending = 0;
    issued = 0;
    cycle = 0;
  end

endmodule

`default_nettype wire

// File: sim/tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster import exec_pkg::*; #(
  parameter int num_lanes = exec_pkg::num_lanes,
  parameter int num_ext_buses = exec_pkg::num_ext_buses,
  localparam int num_buses = num_ext_buses + num_lanes,
  localparam int sel_w = (num_buses > 1) ? $clog2(num_buses) : 1
);

  typedef struct {
    int      lane;
    alu_op_t op;
    logic    narrow;
    src_t    a_src;
    int      a_sel;
    src_t    b_src;
    int      b_sel;
    src_t    f_src;
    int      f_sel;
    int      pat;
    int      adv;
  } row_t;

  logic             clk;
  logic             reset;
  logic             issue_valid [num_lanes];
  alu_op_t          issue_op [num_lanes];
  logic             issue_narrow [num_lanes];
  word_t            issue_a [num_lanes];
  word_t            issue_b [num_lanes];
  flags_t           issue_flags [num_lanes];
  src_t             a_src [num_lanes];
  logic [sel_w-1:0] a_bus_sel [num_lanes];
  src_t             b_src [num_lanes];
  logic [sel_w-1:0] b_bus_sel [num_lanes];
  src_t             flags_src [num_lanes];
  logic [sel_w-1:0] flags_bus_sel [num_lanes];
  word_t            ext_bus_data [num_ext_buses];
  flags_t           ext_bus_flags [num_ext_buses];
  logic             ext_bus_valid [num_ext_buses];
  word_t            result_data [num_lanes];
  flags_t           result_flags [num_lanes];
  logic             result_valid [num_lanes];
  int               pass_count;
  int               fail_count;
  int               pending;
  int               assert_errors [num_lanes];
  logic [31:0]      lfsr;
  row_t             table_q [$];

  exec_cluster #(.num_lanes(num_lanes), .num_ext_buses(num_ext_buses)) dut (.*);

  exec_checker #(.num_lanes(num_lanes), .num_ext_buses(num_ext_buses)) u_checker (.*);

  bind exec_lane exec_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_narrow (issue_narrow),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

  for (genvar l = 0; l < num_lanes; l++) begin : g_assert_errors
    assign assert_errors[l] = dut.g_lane[l].u_lane.u_assert.error_count;
  end

  always #10 clk = ~clk;

  //////////////////////////////
  // Stimulus helpers.
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output word_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[word_w-2:0], lfsr[0]};
    end
  endtask

  task automatic make_operands(input int pat, output word_t a, output word_t b);
    random_bits(word_w, a);
    random_bits(word_w, b);
    case (pat)
      1: begin
        a = '1;
        b = 64'd1;
      end
      2: begin
        a = 64'h7fff_ffff_ffff_ffff;
        b = 64'd1;
      end
      3: begin
        a = 64'h0000_0000_7fff_ffff;
        b = 64'd1;
      end
      4: b = '0;
      5: b = '1;
      6: b = a;
      7: begin
        a = 64'h8000_0000_0000_0000;
        b = 64'd1;
      end
      default: ;
    endcase
  endtask

  task automatic add_row(input int lane, input alu_op_t op, input logic narrow,
                         input src_t as, input int asel, input src_t bs, input int bsel,
                         input src_t fs, input int fsel, input int pat, input int adv);
    row_t r;
    r = '{lane, op, narrow, as, asel, bs, bsel, fs, fsel, pat, adv};
    table_q.push_back(r);
  endtask

  // Idle issue slots and fresh external bus data each cycle.
  task automatic drive_idle();
    word_t w;
    for (int l = 0; l < num_lanes; l++) begin
      issue_valid[l] = 1'b0;
    end
    for (int i = 0; i < num_ext_buses; i++) begin
      random_bits(word_w, w);
      ext_bus_data[i] = w;
    end
  endtask

  task automatic apply_row(input row_t r);
    word_t a;
    word_t b;
    word_t f;
    make_operands(r.pat, a, b);
    random_bits(4, f);
    issue_valid[r.lane] = 1'b1;
    issue_op[r.lane] = r.op;
    issue_narrow[r.lane] = r.narrow;
    issue_a[r.lane] = a;
    issue_b[r.lane] = b;
    issue_flags[r.lane] = flags_t'(f[3:0]);
    a_src[r.lane] = r.a_src;
    a_bus_sel[r.lane] = sel_w'(r.a_sel);
    b_src[r.lane] = r.b_src;
    b_bus_sel[r.lane] = sel_w'(r.b_sel);
    flags_src[r.lane] = r.f_src;
    flags_bus_sel[r.lane] = sel_w'(r.f_sel);
  endtask

  task automatic build_table();
    // Register-sourced arithmetic and logic.
    add_row(0, op_add, 0, src_reg, 0, src_reg, 0, src_reg, 0, 1, 1);
    add_row(0, op_add, 0, src_reg, 0, src_reg, 0, src_reg, 0, 2, 1);
    add_row(1, op_add, 1, src_reg, 0, src_reg, 0, src_reg, 0, 1, 1);
    add_row(1, op_add, 1, src_reg, 0, src_reg, 0, src_reg, 0, 3, 1);
    add_row(0, op_sub, 0, src_reg, 0, src_reg, 0, src_reg, 0, 6, 1);
    add_row(0, op_sub, 0, src_reg, 0, src_reg, 0, src_reg, 0, 7, 1);
    add_row(1, op_sub, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_and, 0, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(1, op_and, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_or, 0, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(1, op_or, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_xor, 0, src_reg, 0, src_reg, 0, src_reg, 0, 6, 1);
    add_row(1, op_xor, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    // Shifts at both widths, zero and maximum amounts.
    add_row(0, op_shl, 0, src_reg, 0, src_reg, 0, src_reg, 0, 4, 1);
    add_row(0, op_shl, 0, src_reg, 0, src_reg, 0, src_reg, 0, 5, 1);
    add_row(1, op_shl, 1, src_reg, 0, src_reg, 0, src_reg, 0, 5, 1);
    add_row(0, op_shr, 0, src_reg, 0, src_reg, 0, src_reg, 0, 5, 1);
    add_row(1, op_shr, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_sar, 0, src_reg, 0, src_reg, 0, src_reg, 0, 7, 1);
    add_row(1, op_sar, 1, src_reg, 0, src_reg, 0, src_reg, 0, 5, 1);
    add_row(1, op_sar, 1, src_reg, 0, src_reg, 0, src_reg, 0, 4, 1);
    // Adc with carry set on bus 0 and clear on bus 1.
    add_row(0, op_adc, 0, src_reg, 0, src_reg, 0, src_bus_now, 0, 1, 1);
    add_row(1, op_adc, 1, src_reg, 0, src_reg, 0, src_bus_now, 1, 0, 1);
    add_row(0, op_adc, 0, src_reg, 0, src_reg, 0, src_bus_prev, 0, 0, 3);
    // Dependent issues on lane 0's result.
    add_row(0, op_add, 0, src_reg, 0, src_reg, 0, src_reg, 0, 0, 2);
    add_row(0, op_xor, 0, src_bus_now, 2, src_reg, 0, src_reg, 0, 0, 0);
    add_row(1, op_sub, 0, src_bus_now, 2, src_reg, 0, src_bus_now, 2, 0, 1);
    add_row(0, op_or, 0, src_bus_prev, 2, src_reg, 0, src_reg, 0, 0, 0);
    add_row(1, op_and, 0, src_reg, 0, src_bus_prev, 2, src_reg, 0, 0, 3);
    // Back-to-back issues in both lanes.
    add_row(0, op_add, 0, src_reg, 0, src_reg, 0, src_reg, 0, 0, 0);
    add_row(1, op_sub, 0, src_reg, 0, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_xor, 1, src_reg, 0, src_bus_now, 3, src_reg, 0, 0, 0);
    add_row(1, op_shr, 0, src_bus_now, 3, src_reg, 0, src_reg, 0, 0, 1);
    add_row(0, op_sar, 1, src_reg, 0, src_reg, 0, src_reg, 0, 0, 0);
    add_row(1, op_or, 0, src_bus_now, 2, src_bus_prev, 3, src_reg, 0, 0, 3);
  endtask

  //////////////////////////////
  // Main sequence.
  //////////////////////////////

  initial begin
    int   i;
    int   tmo;
    int   assert_total;
    logic timed_out;
    clk = 1'b0;
    reset = 1'b1;
    lfsr = 32'd78929;
    timed_out = 1'b0;
    for (int l = 0; l < num_lanes; l++) begin
      issue_valid[l] = 1'b0;
      issue_op[l] = op_add;
      issue_narrow[l] = 1'b0;
      issue_a[l] = '0;
      issue_b[l] = '0;
      issue_flags[l] = '0;
      a_src[l] = src_reg;
      a_bus_sel[l] = '0;
      b_src[l] = src_reg;
      b_bus_sel[l] = '0;
      flags_src[l] = src_reg;
      flags_bus_sel[l] = '0;
    end
    for (int e = 0; e < num_ext_buses; e++) begin
      ext_bus_data[e] = '0;
      ext_bus_valid[e] = 1'b1;
      ext_bus_flags[e] = (e == 0) ? flags_t'(4'b1000) : flags_t'(4'b0010);
    end
    build_table();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    i = 0;
    while (i < table_q.size()) begin
      @(negedge clk);
      drive_idle();
      apply_row(table_q[i]);
      i++;
      // Rows with an advance of zero share the cycle with the next row.
      while (i < table_q.size() && table_q[i-1].adv == 0) begin
        apply_row(table_q[i]);
        i++;
      end
      for (int k = 1; k < table_q[i-1].adv; k++) begin
        @(negedge clk);
        drive_idle();
      end
    end

    tmo = 0;
    while (pending != 0 && tmo < 50) begin
      @(negedge clk);
      drive_idle();
      tmo++;
    end
    if (pending != 0) begin
      $display("timeout while waiting for %0d outstanding results", pending);
      timed_out = 1'b1;
    end
    repeat (4) @(negedge clk);

    assert_total = 0;
    for (int l = 0; l < num_lanes; l++) begin
      assert_total += assert_errors[l];
    end
    $display("tests passed %0d failed %0d assertion failures %0d",
             pass_count, fail_count, assert_total);
    if (!timed_out && fail_count == 0 && assert_total == 0 && pass_count > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/exec_pkg.sv
logic/operand_bypass.sv
logic/op_decode.sv
logic/int_alu.sv
logic/exec_lane.sv
logic/exec_cluster.sv
sim/exec_assert.sv
sim/exec_checker.sv
sim/tb_exec_cluster.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - logic/exec_pkg.sv
  - logic/operand_bypass.sv
  - logic/op_decode.sv
  - logic/int_alu.sv
  - logic/exec_lane.sv
  - logic/exec_cluster.sv
  - target: simulation
    files:
      - sim/exec_assert.sv
      - sim/exec_checker.sv
      - sim/tb_exec_cluster.sv
